/* rtl/booth_pkg.sv */
package booth_pkg;

    // Datapath widths
    localparam int DATA_W = 16;          // Operand width
    localparam int PROD_W = 2 * DATA_W;  // Full signed product
    localparam int GROUPS = DATA_W / 2;  // Radix-4 groups, two multiplier bits each

    // AXI4-Lite address space, five bits cover the 0x00..0x1C window
    localparam int ADDR_W = 5;

    // Register map, word aligned
    localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00;  // Multiplicand, low 16 bits
    localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04;  // Multiplier, low 16 bits
    localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08;  // Bit 0 starts, reads zero
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;  // Bit 0 busy, bit 1 done
    localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10;  // Signed 32-bit product

    // Selected multiple of the multiplicand for one Booth group
    typedef enum logic [2:0] {
        ZERO      = 3'd0,
        PLUS_ONE  = 3'd1,
        PLUS_TWO  = 3'd2,
        MINUS_ONE = 3'd3,
        MINUS_TWO = 3'd4
    } booth_op_e;

    // AXI response codes, only the two this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

/* rtl/mul_req_if.sv */
`timescale 1ns/1ps

// Operation request and result path between register block and Booth engine
interface mul_req_if;

    logic [booth_pkg::DATA_W-1:0] a;              // Multiplicand
    logic [booth_pkg::DATA_W-1:0] b;              // Multiplier
    logic                         issue;          // One-cycle start, a and b sampled here
    logic [booth_pkg::PROD_W-1:0] product;        // Signed product
    logic                         product_valid;  // One-cycle, two cycles after issue

    // Register block side
    modport issuer (
        output a,
        output b,
        output issue,
        input  product,
        input  product_valid
    );

    // Multiplier side, always ready
    modport engine (
        input  a,
        input  b,
        input  issue,
        output product,
        output product_valid
    );

endinterface

/* rtl/booth_encoder.sv */
`timescale 1ns/1ps

module booth_encoder (
    input  logic [2:0]                         group,         // {b[2i+1], b[2i], b[2i-1]}
    input  logic signed [booth_pkg::DATA_W-1:0] multiplicand,
    output booth_pkg::booth_op_e               op,
    output logic signed [booth_pkg::DATA_W:0]   multiple      // One extra bit for the 2x case
);

    logic signed [booth_pkg::DATA_W:0] one_x;  // Sign-extended multiplicand
    logic signed [booth_pkg::DATA_W:0] two_x;  // Multiplicand shifted left by one

    assign one_x = {multiplicand[booth_pkg::DATA_W-1], multiplicand};
    assign two_x = {multiplicand, 1'b0};

    // Standard radix-4 recoding table
    always_comb begin
        case (group)
            3'b001, 3'b010: op = booth_pkg::PLUS_ONE;
            3'b011:         op = booth_pkg::PLUS_TWO;
            3'b100:         op = booth_pkg::MINUS_TWO;
            3'b101, 3'b110: op = booth_pkg::MINUS_ONE;
            default:        op = booth_pkg::ZERO;       // 000 and 111
        endcase
    end

    always_comb begin
        case (op)
            booth_pkg::PLUS_ONE:  multiple = one_x;
            booth_pkg::PLUS_TWO:  multiple = two_x;
            booth_pkg::MINUS_ONE: multiple = -one_x;
            booth_pkg::MINUS_TWO: multiple = -two_x;  // Wraps for -2 * -32768
            default:              multiple = '0;
        endcase
    end

endmodule

/* rtl/booth_multiplier.sv */
`timescale 1ns/1ps

module booth_multiplier (
    input  logic      clk,
    input  logic      rst_n,
    mul_req_if.engine req
);

    logic [booth_pkg::DATA_W:0]          b_ext;                         // b with implied zero
    booth_pkg::booth_op_e                op       [booth_pkg::GROUPS];
    logic signed [booth_pkg::DATA_W:0]   multiple [booth_pkg::GROUPS];
    logic [booth_pkg::PROD_W-1:0]        pp_comb  [booth_pkg::GROUPS];  // Aligned partials
    logic [booth_pkg::PROD_W-1:0]        pp_q     [booth_pkg::GROUPS];  // Stage 1 registers
    logic                                pp_valid_q;
    logic [booth_pkg::PROD_W-1:0]        sum;

    // Bit -1 of the multiplier is zero for the lowest group
    assign b_ext = {req.b, 1'b0};

    for (genvar g = 0; g < booth_pkg::GROUPS; g++) begin : gen_group
        logic neg;       // Opcode subtracts
        logic ext_sign;  // True sign of the multiple

        booth_encoder u_booth_encoder (
            .group        (b_ext[2*g +: 3]),
            .multiplicand (req.a),
            .op           (op[g]),
            .multiple     (multiple[g])
        );

        assign neg = (op[g] == booth_pkg::MINUS_ONE) || (op[g] == booth_pkg::MINUS_TWO);

        // Sign from opcode and multiplicand, not multiple[DATA_W]
        // -2 * -32768 needs 18 bits and shows up negative in the 17-bit multiple
        assign ext_sign = (op[g] != booth_pkg::ZERO) && (req.a != '0)
                          && (neg ^ req.a[booth_pkg::DATA_W-1]);

        // Sign-extend to product width, then weight by 4^g
        assign pp_comb[g] = {{(booth_pkg::PROD_W-booth_pkg::DATA_W-1){ext_sign}},
                             multiple[g]} << (2*g);
    end

    // Stage 1, partial products
    always_ff @(posedge clk) begin
        if (req.issue) begin
            pp_q <= pp_comb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pp_valid_q <= 1'b0;
        end else begin
            pp_valid_q <= req.issue;
        end
    end

    // Adder tree, left to synthesis
    always_comb begin
        sum = '0;
        for (int i = 0; i < booth_pkg::GROUPS; i++) begin
            sum = sum + pp_q[i];  // Modulo 2^PROD_W, carries out are dropped
        end
    end

    // Stage 2, product
    always_ff @(posedge clk) begin
        if (pp_valid_q) begin
            req.product <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.product_valid <= 1'b0;
        end else begin
            req.product_valid <= pp_valid_q;  // Two cycles after issue
        end
    end

endmodule

/* rtl/mul_regs.sv */
`timescale 1ns/1ps

module mul_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    // Write address and data
    input  logic [booth_pkg::ADDR_W-1:0] awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic                         wvalid,
    output logic                         wready,
    // Write response
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    // Read address and data
    input  logic [booth_pkg::ADDR_W-1:0] araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    mul_req_if.issuer                    req
);

    logic                         wr_accept;  // AW and W taken this cycle
    logic                         rd_accept;  // AR taken this cycle
    logic                         start;      // Accepted start while idle
    booth_pkg::axi_resp_e         wr_resp;
    booth_pkg::axi_resp_e         rd_resp;
    logic [31:0]                  rd_data;
    logic [booth_pkg::DATA_W-1:0] opa;
    logic [booth_pkg::DATA_W-1:0] opb;
    logic [booth_pkg::PROD_W-1:0] result;
    logic                         busy;
    logic                         done;

    assign wr_accept = awvalid && awready && wvalid && wready;
    assign rd_accept = arvalid && arready;
    assign start     = wr_accept && (awaddr == booth_pkg::REG_CTRL) && wdata[0] && !busy;

    // Operands go straight out, engine samples them on issue
    assign req.a = opa;
    assign req.b = opb;

    // Write address decode, read-only registers still answer OKAY
    always_comb begin
        case (awaddr)
            booth_pkg::REG_OPA, booth_pkg::REG_OPB, booth_pkg::REG_CTRL,
            booth_pkg::REG_STATUS, booth_pkg::REG_RESULT: wr_resp = booth_pkg::OKAY;
            default:                                      wr_resp = booth_pkg::SLVERR;
        endcase
    end

    // Read mux
    always_comb begin
        rd_resp = booth_pkg::OKAY;
        case (araddr)
            booth_pkg::REG_OPA:    rd_data = {{(32-booth_pkg::DATA_W){1'b0}}, opa};
            booth_pkg::REG_OPB:    rd_data = {{(32-booth_pkg::DATA_W){1'b0}}, opb};
            booth_pkg::REG_CTRL:   rd_data = '0;                    // Start bit is self-clearing
            booth_pkg::REG_STATUS: rd_data = {30'b0, done, busy};
            booth_pkg::REG_RESULT: rd_data = result;
            default: begin
                rd_data = '0;
                rd_resp = booth_pkg::SLVERR;
            end
        endcase
    end

    // Write channel, both readies pulse together for one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (wr_accept) begin
                awready <= 1'b0;
                wready  <= 1'b0;
            end else if (awvalid && wvalid && !bvalid && !awready) begin
                awready <= 1'b1;  // Only with no response pending
                wready  <= 1'b1;
            end
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;   // Held until the master takes it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
            if (awaddr == booth_pkg::REG_OPA) opa <= wdata[booth_pkg::DATA_W-1:0];
            if (awaddr == booth_pkg::REG_OPB) opb <= wdata[booth_pkg::DATA_W-1:0];
        end
    end

    // Read channel, arready low only while a response waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_accept) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else begin
            arready <= !rvalid;  // First cycle out of reset
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data;  // Stable until rready
            rresp <= rd_resp;
        end
    end

    // Operation control, one in flight at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.issue <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            req.issue <= start;  // Start while busy is dropped
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (req.product_valid) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.product_valid) begin
            result <= req.product;
        end
    end

endmodule

/* rtl/booth_mul_top.sv */
`timescale 1ns/1ps

module booth_mul_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [booth_pkg::ADDR_W-1:0] awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [booth_pkg::ADDR_W-1:0] araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready
);

    mul_req_if mul_req ();  // Operands, issue and product

    // AXI4-Lite register block, issues one operation at a time
    mul_regs u_mul_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .req     (mul_req.issuer)
    );

    // Two-stage Booth engine
    booth_multiplier u_booth_multiplier (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mul_req.engine)
    );

endmodule

/* tb/booth_mul_chk.sv */
`timescale 1ns/1ps

module booth_mul_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 bvalid,
    input logic                 bready,
    input logic [1:0]           bresp,
    input logic                 rvalid,
    input logic                 rready,
    input logic [31:0]          rdata,
    input logic                 issue,
    input logic                 product_valid,
    input booth_pkg::booth_op_e op_low  // Opcode of the lowest Booth group
);

    // Write response held with its code until bready
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp changed before bready");

    // Read data held until rready
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid dropped or rdata changed before rready");

    // Fixed two-stage latency in both directions
    assert property (@(posedge clk) disable iff (!rst_n) issue |-> ##2 product_valid)
        else $error("product_valid missing two cycles after issue");
    assert property (@(posedge clk) disable iff (!rst_n) product_valid |-> $past(issue, 2))
        else $error("product_valid without an issue two cycles earlier");

    // No second issue until the product is back and busy has cleared
    assert property (@(posedge clk) disable iff (!rst_n)
        issue |=> !issue ##1 !issue ##1 !issue)
        else $error("issue while an operation was in flight");

    // Implied zero under bit 0 keeps the lowest group off the 2x pattern
    assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> op_low != booth_pkg::PLUS_TWO)
        else $error("Lowest Booth group selected plus two times the multiplicand");

endmodule

bind booth_mul_top booth_mul_chk u_booth_mul_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .bvalid        (bvalid),
    .bready        (bready),
    .bresp         (bresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .issue         (mul_req.issue),
    .product_valid (mul_req.product_valid),
    .op_low        (u_booth_multiplier.op[0])
);

/* tb/booth_mul_tb.sv */
`timescale 1ns/1ps

module booth_mul_tb;

    localparam int NUM_OPS    = 210;                // Corners, random, busy and register tests
    localparam int MAX_CYCLES = 64 * NUM_OPS + 200;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic [booth_pkg::ADDR_W-1:0] awaddr;
    logic                         awvalid;
    logic                         awready;
    logic [31:0]                  wdata;
    logic                         wvalid;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [booth_pkg::ADDR_W-1:0] araddr;
    logic                         arvalid;
    logic                         arready;
    logic [31:0]                  rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
    logic                         rready;

    logic [31:0] seed = 32'h096ac4e5;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       name_q[$];  // Pending comparisons
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       cur_name;
    logic [31:0] cur_exp;
    logic [31:0] cur_act;

    booth_mul_top u_booth_mul_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Signed 16 by 16 product from plain sign extension
    function automatic logic [31:0] ref_product(input logic signed [booth_pkg::DATA_W-1:0] a,
                                                input logic signed [booth_pkg::DATA_W-1:0] b);
        logic signed [31:0] a_ext;
        logic signed [31:0] b_ext;
        a_ext = {{16{a[15]}}, a};
        b_ext = {{16{b[15]}}, b};
        return a_ext * b_ext;
    endfunction

    task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // Response codes widened to the compare width
    task automatic expect_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        expect_value(name, {30'b0, exp}, {30'b0, act});
    endtask

    // Starts driving right after a rising edge
    task automatic axi_write(input logic [booth_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        logic [1:0] held;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= (hold == 0);
        do @(posedge clk); while (!(awready && wready));  // Accepted on this edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        if (hold > 0) begin
            held = bresp;
            repeat (hold) begin
                @(posedge clk);
                assert (bvalid && bresp == held) else begin
                    errors++;
                    $display("Write response dropped or changed while bready was low");
                end
            end
            bready <= 1'b1;
            @(posedge clk);  // Taken here
        end
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [booth_pkg::ADDR_W-1:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        logic [31:0] held;
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        if (hold > 0) begin
            held = rdata;
            repeat (hold) begin
                @(posedge clk);
                assert (rvalid && rdata == held) else begin
                    errors++;
                    $display("Read data dropped or changed while rready was low");
                end
            end
            rready <= 1'b1;
            @(posedge clk);
        end
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] data;
        logic [1:0]  resp;
        do axi_read(booth_pkg::REG_STATUS, 0, data, resp); while (!data[1]);
    endtask

    task automatic run_op(input string name, input logic [15:0] a, input logic [15:0] b);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(booth_pkg::REG_OPA, {16'h0, a}, 0, resp);
        axi_write(booth_pkg::REG_OPB, {16'h0, b}, 0, resp);
        axi_write(booth_pkg::REG_CTRL, 32'h1, 0, resp);
        expect_resp({name, " start resp"}, booth_pkg::OKAY, resp);
        wait_done();
        axi_read(booth_pkg::REG_RESULT, 0, data, resp);
        expect_resp({name, " result resp"}, booth_pkg::OKAY, resp);
        expect_value(name, ref_product(a, b), data);
    endtask

    // Compare process
    always @(posedge clk) begin
        while (act_q.size() > 0) begin
            cur_name = name_q.pop_front();
            cur_exp  = exp_q.pop_front();
            cur_act  = act_q.pop_front();
            checks++;
            assert (cur_act === cur_exp) else begin
                errors++;
                $display("Fail %s expected %h actual %h", cur_name, cur_exp, cur_act);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, DUT stopped responding", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        logic [15:0] a;
        logic [15:0] b;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Corner operands covering all five opcodes
        run_op("zero times any", 16'h0000, 16'h3039);
        run_op("one times minus one", 16'h0001, 16'hffff);
        run_op("max times max", 16'h7fff, 16'h7fff);
        run_op("min times min", 16'h8000, 16'h8000);
        run_op("min times max", 16'h8000, 16'h7fff);

        for (int i = 0; i < 200; i++) begin
            a = 16'(lcg_next() >> 16);  // Upper LCG bits
            b = 16'(lcg_next() >> 16);
            run_op($sformatf("random %0d", i), a, b);
        end

        // Register readback after the last random op
        axi_read(booth_pkg::REG_OPA, 0, data, resp);
        expect_value("opa readback", {16'h0, a}, data);
        axi_read(booth_pkg::REG_OPB, 0, data, resp);
        expect_value("opb readback", {16'h0, b}, data);
        axi_read(booth_pkg::REG_CTRL, 0, data, resp);
        expect_value("ctrl reads zero", 32'h0, data);
        axi_read(booth_pkg::REG_STATUS, 0, data, resp);
        expect_value("status done idle", 32'h2, data);

        // Second start lands three cycles after the first while the engine is still busy
        axi_write(booth_pkg::REG_OPA, 32'h1357, 0, resp);
        axi_write(booth_pkg::REG_OPB, 32'hfedc, 0, resp);
        axi_write(booth_pkg::REG_CTRL, 32'h1, 0, resp);
        axi_write(booth_pkg::REG_CTRL, 32'h1, 0, resp);
        expect_resp("start while busy resp", booth_pkg::OKAY, resp);
        axi_read(booth_pkg::REG_STATUS, 0, data, resp);
        expect_value("start while busy status", 32'h2, data);  // A taken start would show busy
        axi_write(booth_pkg::REG_OPA, 32'h7ace, 0, resp);
        wait_done();
        axi_read(booth_pkg::REG_RESULT, 0, data, resp);
        expect_value("start while busy result", ref_product(16'h1357, 16'hfedc), data);

        // Unmapped offset
        axi_write(5'h14, 32'hdeadbeef, 0, resp);
        expect_resp("unmapped write resp", booth_pkg::SLVERR, resp);
        axi_read(5'h14, 0, data, resp);
        expect_resp("unmapped read resp", booth_pkg::SLVERR, resp);
        expect_value("unmapped read data", 32'h0, data);

        // Ready back-pressure on both response channels
        axi_write(booth_pkg::REG_OPB, 32'h0000a5c3, 6, resp);
        expect_resp("stalled write resp", booth_pkg::OKAY, resp);
        axi_read(booth_pkg::REG_OPB, 6, data, resp);
        expect_value("stalled read data", 32'h0000a5c3, data);

        // Both channels accept again once the stalled responses are taken
        axi_write(booth_pkg::REG_OPA, 32'h00005a3c, 0, resp);
        expect_resp("write after stall resp", booth_pkg::OKAY, resp);
        axi_read(booth_pkg::REG_OPA, 0, data, resp);
        expect_value("read after stall data", 32'h00005a3c, data);

        while (act_q.size() > 0) @(posedge clk);
        @(posedge clk);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/booth_pkg.sv
rtl/mul_req_if.sv
rtl/booth_encoder.sv
rtl/booth_multiplier.sv
rtl/mul_regs.sv
rtl/booth_mul_top.sv
tb/booth_mul_chk.sv
tb/booth_mul_tb.sv

/* Bender.yml */
package:
  name: booth_mul

sources:
  - rtl/booth_pkg.sv
  - rtl/mul_req_if.sv
  - rtl/booth_encoder.sv
  - rtl/booth_multiplier.sv
  - rtl/mul_regs.sv
  - rtl/booth_mul_top.sv
  - target: test
    files:
      - tb/booth_mul_chk.sv
      - tb/booth_mul_tb.sv
